//--- verilog/riscv_dcache_pkg.sv
package riscv_dcache_pkg;

  // memory geometry
  localparam int DATA_WIDTH     = 128;
  localparam int WORD_WIDTH     = 32;
  localparam int CACHE_SIZE     = 1024;                        // bytes
  localparam int MEM_SIZE       = 4096;                        // bytes
  localparam int DATAPBLOCK     = 16;                          // bytes per block
  localparam int CACHE_DEPTH    = CACHE_SIZE / DATAPBLOCK;     // 64 lines

  // address split
  localparam int ADDR           = $clog2(MEM_SIZE);            // 12
  localparam int BYTE_OFF       = $clog2(DATAPBLOCK);          // 4
  localparam int INDEX          = $clog2(CACHE_DEPTH);         // 6
  localparam int TAG            = ADDR - BYTE_OFF - INDEX;     // 2
  localparam int S_ADDR         = ADDR - BYTE_OFF;             // block address
  localparam int WORDS_PER_LINE = DATA_WIDTH / WORD_WIDTH;     // 4
  localparam int WORD_SEL       = $clog2(WORDS_PER_LINE);

  localparam int DRAM_LATENCY   = 8;

  typedef struct packed {
    logic [TAG-1:0]                 tag;
    logic [INDEX-1:0]               index;
    logic [WORD_SEL-1:0]            word;
    logic [BYTE_OFF-WORD_SEL-1:0]   byte_off;  // unused, word accesses only
  } dcache_addr_t;

  typedef struct packed {
    logic           valid;
    logic           dirty;
    logic [TAG-1:0] tag;
  } dcache_tag_t;

  // raw block for the memory side, words for select and merge
  typedef union packed {
    logic [DATA_WIDTH-1:0]                      raw;
    logic [WORDS_PER_LINE-1:0][WORD_WIDTH-1:0]  words;
  } dcache_line_u;

  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    WRITEBACK,
    REFILL,
    RESPOND
  } dcache_state_e;

endpackage

//--- verilog/riscv_dram_timer.sv
`timescale 1ns/1ps

module riscv_dram_timer (
  input  logic clk,
  input  logic rst_n,
  input  logic timer_start,
  output logic timer_done
);

  import riscv_dcache_pkg::*;

  logic                              running_q;
  logic [$clog2(DRAM_LATENCY)-1:0]   count_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      running_q <= 1'b0;
      count_q   <= '0;
    end else if (timer_start) begin
      running_q <= 1'b1;
      count_q   <= $bits(count_q)'(DRAM_LATENCY - 1);
    end else if (running_q) begin
      if (count_q == '0) begin
        running_q <= 1'b0;
      end else begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // high for the single cycle the count sits at zero
  assign timer_done = running_q && (count_q == '0);

endmodule

//--- verilog/riscv_dcache_tags.sv
`timescale 1ns/1ps

module riscv_dcache_tags (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic [riscv_dcache_pkg::INDEX-1:0]  arr_index,
  input  logic                                tag_wr,
  input  riscv_dcache_pkg::dcache_tag_t       tag_wr_entry,
  output riscv_dcache_pkg::dcache_tag_t       tag_rd_entry
);

  import riscv_dcache_pkg::*;

  logic [CACHE_DEPTH-1:0]  valid_q;
  logic [TAG:0]            meta_mem [CACHE_DEPTH];  // {dirty, tag}
  logic                    rd_valid_q;
  logic [TAG:0]            rd_meta_q;

  // valid bits live in flops so reset can clear them
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q    <= '0;
      rd_valid_q <= 1'b0;
    end else begin
      rd_valid_q <= valid_q[arr_index];
      if (tag_wr) valid_q[arr_index] <= tag_wr_entry.valid;
    end
  end

  always_ff @(posedge clk) begin
    rd_meta_q <= meta_mem[arr_index];  // old entry on a same-cycle write
    if (tag_wr) begin
      meta_mem[arr_index] <= {tag_wr_entry.dirty, tag_wr_entry.tag};
    end
  end

  assign tag_rd_entry.valid = rd_valid_q;
  assign tag_rd_entry.dirty = rd_meta_q[TAG];
  assign tag_rd_entry.tag   = rd_meta_q[TAG-1:0];

endmodule

//--- verilog/riscv_dcache_data.sv
`timescale 1ns/1ps

module riscv_dcache_data (
  input  logic                                     clk,
  input  logic [riscv_dcache_pkg::INDEX-1:0]       arr_index,
  input  logic                                     line_wr,
  input  riscv_dcache_pkg::dcache_line_u           line_wr_data,
  input  logic                                     merge_en,
  input  logic [riscv_dcache_pkg::WORD_SEL-1:0]    merge_word,
  input  logic [riscv_dcache_pkg::WORD_WIDTH-1:0]  merge_data,
  output riscv_dcache_pkg::dcache_line_u           line_rd
);

  import riscv_dcache_pkg::*;

  dcache_line_u  line_mem [CACHE_DEPTH];
  dcache_line_u  wr_line;

  // whole line, or the line with one word swapped in
  always_comb begin
    wr_line = line_wr_data;
    if (merge_en) begin
      wr_line.words[merge_word] = merge_data;
    end
  end

  always_ff @(posedge clk) begin
    if (line_wr) begin
      line_mem[arr_index] <= wr_line;
    end
  end

  always_ff @(posedge clk) begin
    line_rd <= line_mem[arr_index];  // registered read
  end

endmodule

//--- verilog/riscv_dram_data.sv
`timescale 1ns/1ps

module riscv_dram_data (
  input  logic                                     clk,
  input  logic                                     wren,
  input  logic                                     rden,
  input  logic [riscv_dcache_pkg::S_ADDR-1:0]      addr,
  input  logic [riscv_dcache_pkg::DATA_WIDTH-1:0]  data_in,
  output logic [riscv_dcache_pkg::DATA_WIDTH-1:0]  data_out
);

  import riscv_dcache_pkg::*;

  genvar lane;

  // one byte-wide array per lane, lane 0 holds bits 7:0
  for (lane = 0; lane < DATAPBLOCK; lane++) begin : g_lane
    logic [7:0] lane_mem [MEM_SIZE/DATAPBLOCK];
    logic [7:0] lane_rd_q;

    initial begin
      for (int i = 0; i < MEM_SIZE/DATAPBLOCK; i++) begin
        lane_mem[i] = 8'h00;
      end
    end

    // read wins over write
    always_ff @(posedge clk) begin
      if (wren && !rden) begin
        lane_mem[addr] <= data_in[lane*8 +: 8];
      end
    end

    always_ff @(posedge clk) begin
      lane_rd_q <= lane_mem[addr];
    end

    assign data_out[lane*8 +: 8] = lane_rd_q;
  end

endmodule

//--- verilog/riscv_dcache_ctrl.sv
`timescale 1ns/1ps

module riscv_dcache_ctrl (
  input  logic                                     clk,
  input  logic                                     rst_n,
  input  logic                                     cpu_rd,
  input  logic                                     cpu_wr,
  input  riscv_dcache_pkg::dcache_addr_t           cpu_addr,
  input  logic [riscv_dcache_pkg::WORD_WIDTH-1:0]  cpu_wdata,
  input  riscv_dcache_pkg::dcache_tag_t            tag_rd_entry,
  input  riscv_dcache_pkg::dcache_line_u           line_rd,
  input  riscv_dcache_pkg::dcache_line_u           dram_data_out,
  input  logic                                     timer_done,
  output logic [riscv_dcache_pkg::WORD_WIDTH-1:0]  cpu_rdata,
  output logic                                     cpu_done,
  output logic                                     cpu_busy,
  output logic [riscv_dcache_pkg::INDEX-1:0]       arr_index,
  output logic                                     tag_wr,
  output riscv_dcache_pkg::dcache_tag_t            tag_wr_entry,
  output logic                                     line_wr,
  output riscv_dcache_pkg::dcache_line_u           line_wr_data,
  output logic                                     merge_en,
  output logic [riscv_dcache_pkg::WORD_SEL-1:0]    merge_word,
  output logic [riscv_dcache_pkg::WORD_WIDTH-1:0]  merge_data,
  output logic                                     dram_rden,
  output logic                                     dram_wren,
  output logic [riscv_dcache_pkg::S_ADDR-1:0]      dram_addr,
  output logic                                     timer_start
);

  import riscv_dcache_pkg::*;

  dcache_state_e          state_q, state_d;
  dcache_addr_t           req_q;       // latched request address
  logic [WORD_WIDTH-1:0]  wdata_q;
  logic                   req_wr_q;
  logic [WORD_WIDTH-1:0]  rdata_q, rdata_d;
  logic                   hit;
  logic                   victim_dirty;

  assign hit          = tag_rd_entry.valid && (tag_rd_entry.tag == req_q.tag);
  assign victim_dirty = tag_rd_entry.valid && tag_rd_entry.dirty;

  // arrays follow the incoming address while idle
  assign arr_index = (state_q == IDLE) ? cpu_addr.index : req_q.index;

  // same entry serves write hit and refill
  assign tag_wr_entry.valid = 1'b1;
  assign tag_wr_entry.dirty = req_wr_q;
  assign tag_wr_entry.tag   = req_q.tag;

  assign merge_en   = req_wr_q;
  assign merge_word = req_q.word;
  assign merge_data = wdata_q;

  always_comb begin
    state_d      = state_q;
    rdata_d      = rdata_q;
    tag_wr       = 1'b0;
    line_wr      = 1'b0;
    line_wr_data = line_rd;
    case (state_q)
      IDLE: begin
        if (cpu_rd || cpu_wr) state_d = LOOKUP;
      end
      LOOKUP: begin
        if (hit) begin
          state_d = RESPOND;
          tag_wr  = req_wr_q;  // sets dirty on a store
          line_wr = req_wr_q;
          rdata_d = req_wr_q ? wdata_q : line_rd.words[req_q.word];
        end else if (victim_dirty) begin
          state_d = WRITEBACK;
        end else begin
          state_d = REFILL;
        end
      end
      WRITEBACK: begin
        if (timer_done) state_d = REFILL;
      end
      REFILL: begin
        if (timer_done) begin
          state_d      = RESPOND;
          tag_wr       = 1'b1;
          line_wr      = 1'b1;
          line_wr_data = dram_data_out;  // store word merged in the array
          rdata_d      = req_wr_q ? wdata_q : dram_data_out.words[req_q.word];
        end
      end
      RESPOND: state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= IDLE;
      req_wr_q    <= 1'b0;
      timer_start <= 1'b0;
    end else begin
      state_q     <= state_d;
      // first cycle of each memory phase
      timer_start <= (state_d != state_q) &&
                     ((state_d == WRITEBACK) || (state_d == REFILL));
      if (state_q == IDLE && (cpu_rd || cpu_wr)) req_wr_q <= cpu_wr;
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == IDLE && (cpu_rd || cpu_wr)) begin
      req_q   <= cpu_addr;
      wdata_q <= cpu_wdata;
    end
    rdata_q <= rdata_d;
  end

  assign cpu_rdata = rdata_q;
  assign cpu_done  = (state_q == RESPOND);
  assign cpu_busy  = (state_q != IDLE);

  assign dram_wren = (state_q == WRITEBACK);
  assign dram_rden = (state_q == REFILL);
  // victim block address during writeback, request block otherwise
  assign dram_addr = (state_q == WRITEBACK) ? {tag_rd_entry.tag, req_q.index}
                                            : {req_q.tag, req_q.index};

endmodule

//--- verilog/riscv_dcache_top.sv
`timescale 1ns/1ps

module riscv_dcache_top (
  input  logic                                     clk,
  input  logic                                     rst_n,
  input  logic                                     cpu_rd,
  input  logic                                     cpu_wr,
  input  riscv_dcache_pkg::dcache_addr_t           cpu_addr,
  input  logic [riscv_dcache_pkg::WORD_WIDTH-1:0]  cpu_wdata,
  output logic [riscv_dcache_pkg::WORD_WIDTH-1:0]  cpu_rdata,
  output logic                                     cpu_done,
  output logic                                     cpu_busy
);

  import riscv_dcache_pkg::*;

  // array side
  logic [INDEX-1:0]       arr_index;
  logic                   tag_wr;
  dcache_tag_t            tag_wr_entry;
  dcache_tag_t            tag_rd_entry;
  logic                   line_wr;
  dcache_line_u           line_wr_data;
  dcache_line_u           line_rd;
  logic                   merge_en;
  logic [WORD_SEL-1:0]    merge_word;
  logic [WORD_WIDTH-1:0]  merge_data;

  // memory side
  logic                   dram_rden;
  logic                   dram_wren;
  logic [S_ADDR-1:0]      dram_addr;
  dcache_line_u           dram_data_out;
  logic                   timer_start;
  logic                   timer_done;

  riscv_dcache_ctrl i_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .cpu_rd        (cpu_rd),
    .cpu_wr        (cpu_wr),
    .cpu_addr      (cpu_addr),
    .cpu_wdata     (cpu_wdata),
    .tag_rd_entry  (tag_rd_entry),
    .line_rd       (line_rd),
    .dram_data_out (dram_data_out),
    .timer_done    (timer_done),
    .cpu_rdata     (cpu_rdata),
    .cpu_done      (cpu_done),
    .cpu_busy      (cpu_busy),
    .arr_index     (arr_index),
    .tag_wr        (tag_wr),
    .tag_wr_entry  (tag_wr_entry),
    .line_wr       (line_wr),
    .line_wr_data  (line_wr_data),
    .merge_en      (merge_en),
    .merge_word    (merge_word),
    .merge_data    (merge_data),
    .dram_rden     (dram_rden),
    .dram_wren     (dram_wren),
    .dram_addr     (dram_addr),
    .timer_start   (timer_start)
  );

  riscv_dram_timer i_timer (
    .clk         (clk),
    .rst_n       (rst_n),
    .timer_start (timer_start),
    .timer_done  (timer_done)
  );

  riscv_dcache_tags i_tags (
    .clk          (clk),
    .rst_n        (rst_n),
    .arr_index    (arr_index),
    .tag_wr       (tag_wr),
    .tag_wr_entry (tag_wr_entry),
    .tag_rd_entry (tag_rd_entry)
  );

  riscv_dcache_data i_data (
    .clk          (clk),
    .arr_index    (arr_index),
    .line_wr      (line_wr),
    .line_wr_data (line_wr_data),
    .merge_en     (merge_en),
    .merge_word   (merge_word),
    .merge_data   (merge_data),
    .line_rd      (line_rd)
  );

  // victim line goes straight from the data array to memory
  riscv_dram_data i_dram (
    .clk      (clk),
    .wren     (dram_wren),
    .rden     (dram_rden),
    .addr     (dram_addr),
    .data_in  (line_rd.raw),
    .data_out (dram_data_out.raw)
  );

endmodule

//--- verification/riscv_dcache_assertions.sv
`timescale 1ns/1ps

module riscv_dcache_assertions (
  input logic clk,
  input logic rst_n,
  input logic cpu_done,
  input logic cpu_busy,
  input logic dram_rden,
  input logic dram_wren,
  input logic timer_start
);

  // response is a single-cycle pulse
  a_done_pulse: assert property (
    @(posedge clk) disable iff (!rst_n) cpu_done |=> !cpu_done
  ) else $error("cpu_done stayed high for more than one cycle");

  a_mem_exclusive: assert property (
    @(posedge clk) disable iff (!rst_n) !(dram_rden && dram_wren)
  ) else $error("dram_rden and dram_wren high together");

  // any memory phase sits inside a busy window
  a_busy_in_mem: assert property (
    @(posedge clk) disable iff (!rst_n) (dram_rden || dram_wren || timer_start) |-> cpu_busy
  ) else $error("memory phase active while cpu_busy is low");

endmodule

//--- verification/riscv_dcache_tb.sv
`timescale 1ns/1ps

module riscv_dcache_tb;

  import riscv_dcache_pkg::*;

  localparam int NUM_ACCESSES = 221;                // sum over all tests below
  localparam int CYCLE_LIMIT  = 40 * NUM_ACCESSES;

  logic                   clk;
  logic                   rst_n;
  logic                   cpu_rd;
  logic                   cpu_wr;
  dcache_addr_t           cpu_addr;
  logic [WORD_WIDTH-1:0]  cpu_wdata;
  logic [WORD_WIDTH-1:0]  cpu_rdata;
  logic                   cpu_done;
  logic                   cpu_busy;

  logic [WORD_WIDTH-1:0]  model_mem [MEM_SIZE/4];  // expected word per word address
  int                     seed;
  int                     checks;
  int                     errors;
  int                     tests_run;
  int                     tests_failed;

  riscv_dcache_top i_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .cpu_rd    (cpu_rd),
    .cpu_wr    (cpu_wr),
    .cpu_addr  (cpu_addr),
    .cpu_wdata (cpu_wdata),
    .cpu_rdata (cpu_rdata),
    .cpu_done  (cpu_done),
    .cpu_busy  (cpu_busy)
  );

  bind riscv_dcache_ctrl riscv_dcache_assertions i_assertions (
    .clk         (clk),
    .rst_n       (rst_n),
    .cpu_done    (cpu_done),
    .cpu_busy    (cpu_busy),
    .dram_rden   (dram_rden),
    .dram_wren   (dram_wren),
    .timer_start (timer_start)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  // one-cycle strobe, then count cycles up to cpu_done
  task automatic issue_access(input logic is_wr, input logic [ADDR-1:0] addr,
                              input logic [WORD_WIDTH-1:0] wdata,
                              output int cycles, output logic [WORD_WIDTH-1:0] rdata);
    logic busy_ok;
    @(posedge clk);
    cpu_rd    <= !is_wr;
    cpu_wr    <= is_wr;
    cpu_addr  <= addr;
    cpu_wdata <= wdata;
    @(posedge clk);  // DUT samples the request here
    cpu_rd <= 1'b0;
    cpu_wr <= 1'b0;
    cycles  = 0;
    busy_ok = 1'b1;
    do begin
      @(negedge clk);
      cycles++;
      if (!cpu_busy) busy_ok = 1'b0;
    end while (!cpu_done);
    rdata = cpu_rdata;
    checks++;
    if (!busy_ok) begin
      errors++;
      $display("cpu_busy dropped during the access to 0x%03h", addr);
    end
    @(negedge clk);  // back in idle
    checks++;
    if (cpu_busy !== 1'b0) begin
      errors++;
      $display("ERROR cpu_busy after done 0x%03h: got 0x%0h, expected 0x0", addr, cpu_busy);
    end
  endtask

  task automatic read_check(input logic [ADDR-1:0] addr, output int cycles);
    logic [WORD_WIDTH-1:0] got;
    logic [WORD_WIDTH-1:0] exp;
    exp = model_mem[addr[ADDR-1:2]];
    issue_access(1'b0, addr, '0, cycles, got);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR cpu_rdata read 0x%03h: got 0x%08h, expected 0x%08h", addr, got, exp);
    end
  endtask

  task automatic write_check(input logic [ADDR-1:0] addr, input logic [WORD_WIDTH-1:0] wdata,
                             output int cycles);
    logic [WORD_WIDTH-1:0] got;
    model_mem[addr[ADDR-1:2]] = wdata;
    issue_access(1'b1, addr, wdata, cycles, got);
    checks++;
    if (got !== wdata) begin  // merged word comes back on a store
      errors++;
      $display("ERROR cpu_rdata write 0x%03h: got 0x%08h, expected 0x%08h", addr, got, wdata);
    end
  endtask

  task automatic expect_hit(input int cycles, input logic [ADDR-1:0] addr);
    checks++;
    if (cycles != 2) begin
      errors++;
      $display("hit on address 0x%03h took %0d cycles instead of 2", addr, cycles);
    end
  endtask

  task automatic report_result(input string name, input int err_start);
    tests_run++;
    if (errors != err_start) begin
      tests_failed++;
      $display("%s: failed with %0d errors", name, errors - err_start);
    end else begin
      $display("%s: ok", name);
    end
  endtask

  task automatic reset_reads();
    int err_start;
    int cycles;
    err_start = errors;
    read_check(12'h000, cycles);
    read_check(12'h7F4, cycles);
    read_check(12'hC38, cycles);
    read_check(12'hFFC, cycles);  // same index as 0x7F4, clean eviction
    report_result("reset_reads", err_start);
  endtask

  task automatic write_then_read();
    int err_start;
    int cycles;
    err_start = errors;
    write_check(12'h124, 32'hDEAD_BEEF, cycles);
    read_check(12'h124, cycles);
    expect_hit(cycles, 12'h124);
    report_result("write_then_read", err_start);
  endtask

  task automatic miss_then_hit();
    int err_start;
    int cycles;
    err_start = errors;
    read_check(12'h2A8, cycles);  // line not touched so far
    checks++;
    if (cycles < DRAM_LATENCY) begin
      errors++;
      $display("first access to 0x2a8 took only %0d cycles, too short for a refill", cycles);
    end
    read_check(12'h2A8, cycles);
    expect_hit(cycles, 12'h2A8);
    report_result("miss_then_hit", err_start);
  endtask

  task automatic conflict_eviction();
    int err_start;
    int cycles;
    logic [ADDR-1:0] addr_a;
    logic [ADDR-1:0] addr_b;
    err_start = errors;
    addr_a = 12'h350;
    addr_b = addr_a + 12'h400;  // same index, next tag
    write_check(addr_a, 32'h1111_AAAA, cycles);
    write_check(addr_b, 32'h2222_BBBB, cycles);
    checks++;
    if (cycles < 2 * DRAM_LATENCY) begin
      errors++;
      $display("write to B took %0d cycles, dirty line A was not written back", cycles);
    end
    read_check(addr_a, cycles);
    checks++;
    if (cycles < 2 * DRAM_LATENCY) begin
      errors++;
      $display("read of A took %0d cycles, too short for writeback and refill", cycles);
    end
    read_check(addr_b, cycles);
    report_result("conflict_eviction", err_start);
  endtask

  task automatic neighbour_words();
    int err_start;
    int cycles;
    logic [ADDR-1:0] base;
    err_start = errors;
    base = 12'h5C0;
    for (int w = 0; w < WORDS_PER_LINE; w++) begin
      write_check(base + 12'(w * 4), 32'hA5A5_0000 | 32'(w), cycles);
    end
    write_check(base + 12'h008, 32'h0BAD_CAFE, cycles);  // word 2 only
    for (int w = 0; w < WORDS_PER_LINE; w++) begin
      read_check(base + 12'(w * 4), cycles);
    end
    report_result("neighbour_words", err_start);
  endtask

  task automatic random_mix();
    int err_start;
    int cycles;
    int rnd;
    logic [ADDR-1:0] addr;
    logic [WORD_WIDTH-1:0] wdata;
    err_start = errors;
    for (int n = 0; n < 200; n++) begin
      rnd  = $random(seed);
      addr = {rnd[9:0], 2'b00};
      if (rnd[16]) begin
        wdata = $random(seed);
        write_check(addr, wdata, cycles);
      end else begin
        read_check(addr, cycles);
      end
    end
    report_result("random_mix", err_start);
  endtask

  // watchdog
  initial begin
    int cycle_count;
    cycle_count = 0;
    while (cycle_count < CYCLE_LIMIT) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout after %0d cycles, the DUT stopped answering", CYCLE_LIMIT);
    $display("Regression failed");
    $finish;
  end

  initial begin
    seed         = 38336;
    checks       = 0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    for (int i = 0; i < MEM_SIZE/4; i++) begin
      model_mem[i] = '0;
    end
    rst_n     = 1'b0;
    cpu_rd    = 1'b0;
    cpu_wr    = 1'b0;
    cpu_addr  = '0;
    cpu_wdata = '0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;

    reset_reads();
    write_then_read();
    miss_then_hit();
    conflict_eviction();
    neighbour_words();
    random_mix();

    $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, checks, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

//--- verilog.f
verilog/riscv_dcache_pkg.sv
verilog/riscv_dram_timer.sv
verilog/riscv_dcache_tags.sv
verilog/riscv_dcache_data.sv
verilog/riscv_dram_data.sv
verilog/riscv_dcache_ctrl.sv
verilog/riscv_dcache_top.sv
verification/riscv_dcache_assertions.sv
verification/riscv_dcache_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the dcache regression, exit status follows the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert --top-module riscv_dcache_tb -f verilog.f \
  > build.log 2>&1 || { cat build.log; echo "verilator build failed"; exit 1; }

./obj_dir/Vriscv_dcache_tb > sim.log 2>&1
cat sim.log

grep -qx "Regression passed" sim.log && echo "status: pass" || { echo "status: fail"; exit 1; }
